// File: turfio_consts.svh
`ifndef TURFIO_CONSTS_SVH
`define TURFIO_CONSTS_SVH

// Ident word, ASCII "TFIO"
`define TIO_IDENT       32'h5446_494F

// Firmware version fields
`define TIO_VER_MAJOR   4'd0
`define TIO_VER_MINOR   4'd2
`define TIO_VER_REV     8'd6
// Packed firmware date, unset in this build
`define TIO_FW_DATE     16'h0000

// Space field of the byte address, zero means local
`define SPACE_HI        24
`define SPACE_LO        22
// Window field, one 4 KB window per module
`define WIN_HI          21
`define WIN_LO          12

// Window numbers
`define WIN_ID_CTRL     10'd0
`define WIN_HSKBUS      10'd1

// Window 0 register offsets
`define REG_IDENT       12'h000
`define REG_DATEVER     12'h004
`define REG_CTRL        12'h008
`define REG_STATUS      12'h00C
// Window 1 register offsets
`define REG_HSK_CTRL    12'h000
`define REG_HSK_STAT    12'h004

`endif

// File: turfio_pkg.sv
package turfio_pkg;

    ////////////////////////////////////////
    // Wishbone port types
    ////////////////////////////////////////

    // Byte address on the debug Wishbone port
    // Bits 24:22 pick the space, 21:12 the window
    typedef logic [24:0] wb_addr_t;

    // Full 32-bit data word, no byte lanes
    typedef logic [31:0] wb_data_t;

    // Byte offset inside one 4 KB module window
    typedef logic [11:0] win_addr_t;

    ////////////////////////////////////////
    // Board pin types
    ////////////////////////////////////////

    // Crate configuration straps
    typedef logic [1:0] crate_conf_t;

endpackage

// File: turfio_intercon.sv
`timescale 1ns/100ps
`include "turfio_consts.svh"

module turfio_intercon (
    input  logic                   init_clk,
    input  logic                   rst_n_i,
    // Master side
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  turfio_pkg::wb_addr_t   wb_adr_i,
    input  turfio_pkg::wb_data_t   wb_dat_i,
    output turfio_pkg::wb_data_t   wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   wb_err_o,
    // Window 0 slave
    input  turfio_pkg::wb_data_t   id_dat_i,
    input  logic                   id_ack_i,
    output logic                   id_stb_o,
    // Window 1 slave
    input  turfio_pkg::wb_data_t   hsk_dat_i,
    input  logic                   hsk_ack_i,
    output logic                   hsk_stb_o,
    // Shared slave request fields
    output logic                   s_we_o,
    output turfio_pkg::win_addr_t  s_adr_o,
    output turfio_pkg::wb_data_t   s_dat_o
);

    import turfio_pkg::*;

    // Address fields
    logic [`SPACE_HI-`SPACE_LO:0] space;
    logic [`WIN_HI-`WIN_LO:0]     win;

    // Decode results
    logic     req;
    logic     local_sp;
    logic     id_sel;
    logic     hsk_sel;
    logic     unmapped;

    // Error responder state
    logic     err_q;
    logic     err_done_q;

    // Response data
    wb_data_t rd_mux;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign space = wb_adr_i[`SPACE_HI:`SPACE_LO];
    assign win   = wb_adr_i[`WIN_HI:`WIN_LO];

    // Live request from the master
    assign req      = wb_cyc_i & wb_stb_i;
    // Non-zero space is the SURF bridge, not built here
    assign local_sp = (space == '0);
    assign id_sel   = local_sp & (win == `WIN_ID_CTRL);
    assign hsk_sel  = local_sp & (win == `WIN_HSKBUS);
    // Everything else falls to the error responder
    assign unmapped = req & ~id_sel & ~hsk_sel;

    // Per-slave strobes
    assign id_stb_o  = req & id_sel;
    assign hsk_stb_o = req & hsk_sel;

    // Shared request fields fan out unchanged
    assign s_we_o  = wb_we_i;
    assign s_adr_o = wb_adr_i[`WIN_LO-1:0];
    assign s_dat_o = wb_dat_i;

    ////////////////////////////////////////
    // Error responder
    ////////////////////////////////////////

    // One-cycle err after an unmapped request
    // Done flag blocks a repeat until stb drops
    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q      <= 1'b0;
            err_done_q <= 1'b0;
        end else begin
            if (unmapped && !err_done_q) begin
                err_q      <= 1'b1;
                err_done_q <= 1'b1;
            end else begin
                err_q <= 1'b0;
                // Rearm once the master lets go
                if (!wb_stb_i) begin
                    err_done_q <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Response mux
    ////////////////////////////////////////

    // Steer by which slave is acking, zero on err
    always_comb begin
        rd_mux = '0;
        if (id_ack_i) begin
            rd_mux = id_dat_i;
        end else if (hsk_ack_i) begin
            rd_mux = hsk_dat_i;
        end
    end

    assign wb_dat_o = rd_mux;
    // At most one slave strobed, so OR is safe
    assign wb_ack_o = id_ack_i | hsk_ack_i;
    assign wb_err_o = err_q;

endmodule

// File: tio_id_ctrl.sv
`timescale 1ns/100ps
`include "turfio_consts.svh"

module tio_id_ctrl (
    input  logic                     init_clk,
    input  logic                     rst_n_i,
    // Slave port from the decoder
    input  logic                     stb_i,
    input  logic                     we_i,
    input  turfio_pkg::win_addr_t    adr_i,
    input  turfio_pkg::wb_data_t     dat_i,
    output turfio_pkg::wb_data_t     dat_o,
    output logic                     ack_o,
    // Board pins
    input  turfio_pkg::crate_conf_t  crate_conf_i,
    input  logic                     i2c_rdy_i,
    output logic                     enable_crate_o,
    output logic                     enable_3v3_o
);

    import turfio_pkg::*;

    // Date and version packed high to low
    localparam wb_data_t DATEVER = {`TIO_FW_DATE, `TIO_VER_MAJOR,
                                    `TIO_VER_MINOR, `TIO_VER_REV};

    // Handshake state
    logic     ack_q;
    logic     done_q;
    logic     serve;

    // Control bits
    logic     en_crate_q;
    logic     en_3v3_q;

    // Read path
    wb_data_t rd_val;
    wb_data_t dat_q;

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // Serve once per strobe
    assign serve = stb_i & ~done_q;

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q <= serve;
            if (serve) begin
                done_q <= 1'b1;
            end else if (!stb_i) begin
                done_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Control register
    ////////////////////////////////////////

    // Write lands on the same edge as ack
    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_crate_q <= 1'b0;
            en_3v3_q   <= 1'b0;
        end else if (serve && we_i && (adr_i == `REG_CTRL)) begin
            en_crate_q <= dat_i[0];
            en_3v3_q   <= dat_i[1];
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    // Unknown offsets read zero
    always_comb begin
        case (adr_i)
            `REG_IDENT:   rd_val = `TIO_IDENT;
            `REG_DATEVER: rd_val = DATEVER;
            `REG_CTRL:    rd_val = {30'd0, en_3v3_q, en_crate_q};
            // Straps low, I2C ready above them
            `REG_STATUS:  rd_val = {29'd0, i2c_rdy_i, crate_conf_i};
            default:      rd_val = '0;
        endcase
    end

    // Capture read data alongside ack
    always_ff @(posedge init_clk) begin
        if (serve) begin
            dat_q <= rd_val;
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

    // Enables straight from the register
    assign enable_crate_o = en_crate_q;
    assign enable_3v3_o   = en_3v3_q;

endmodule

// File: hskbus_route.sv
`timescale 1ns/100ps
`include "turfio_consts.svh"

module hskbus_route (
    input  logic                   init_clk,
    input  logic                   rst_n_i,
    // Slave port from the decoder
    input  logic                   stb_i,
    input  logic                   we_i,
    input  turfio_pkg::win_addr_t  adr_i,
    input  turfio_pkg::wb_data_t   dat_i,
    output turfio_pkg::wb_data_t   dat_o,
    output logic                   ack_o,
    // Serial lines
    input  logic                   tctrl_b_i,
    input  logic                   dbg_rx_i,
    input  logic                   turf_rx_i,
    input  logic                   surf_tx_i,
    output logic                   dbg_tx_o,
    output logic                   turf_tx_o,
    output logic                   surf_rx_o
);

    import turfio_pkg::*;

    // Handshake state
    logic     ack_q;
    logic     done_q;
    logic     serve;

    // Routing control
    logic     hsk_local_q;
    logic     bridge_en_q;

    // Read path
    wb_data_t rd_val;
    wb_data_t dat_q;

    // Internal UART nets, all idle high
    logic     turf_rx_gated;
    logic     crate_tx;
    logic     crate_rx;

    // One response per strobe
    assign serve = stb_i & ~done_q;

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q       <= 1'b0;
            done_q      <= 1'b0;
            hsk_local_q <= 1'b0;
            bridge_en_q <= 1'b0;
        end else begin
            ack_q <= serve;
            if (serve) begin
                done_q <= 1'b1;
            end else if (!stb_i) begin
                done_q <= 1'b0;
            end
            // Control write takes effect with ack
            if (serve && we_i && (adr_i == `REG_HSK_CTRL)) begin
                hsk_local_q <= dat_i[0];
                bridge_en_q <= dat_i[1];
            end
        end
    end

    // Control and status readback
    always_comb begin
        case (adr_i)
            `REG_HSK_CTRL: rd_val = {30'd0, bridge_en_q, hsk_local_q};
            `REG_HSK_STAT: rd_val = {31'd0, tctrl_b_i};
            default:       rd_val = '0;
        endcase
    end

    always_ff @(posedge init_clk) begin
        if (serve) begin
            dat_q <= rd_val;
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

    ////////////////////////////////////////
    // UART routing
    ////////////////////////////////////////

    // TURF line only valid with tctrl_b low
    assign turf_rx_gated = tctrl_b_i ? 1'b1 : turf_rx_i;
    // Local mode hands the crate to the debug port
    assign crate_tx = hsk_local_q ? dbg_rx_i : turf_rx_gated;
    // Bridge gates both directions to the SURFs
    assign surf_rx_o = bridge_en_q ? crate_tx : 1'b1;
    assign crate_rx  = bridge_en_q ? surf_tx_i : 1'b1;
    // Return path goes to whichever side owns the bus
    assign dbg_tx_o  = hsk_local_q ? crate_rx : 1'b1;
    assign turf_tx_o = hsk_local_q ? 1'b1 : crate_rx;

endmodule

// File: turfio_top.sv
`timescale 1ns/100ps

module turfio_top (
    input  logic                     init_clk,
    input  logic                     rst_n_i,
    // Debug master Wishbone port
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  turfio_pkg::wb_addr_t     wb_adr_i,
    input  turfio_pkg::wb_data_t     wb_dat_i,
    output turfio_pkg::wb_data_t     wb_dat_o,
    output logic                     wb_ack_o,
    output logic                     wb_err_o,
    // Crate pins
    input  turfio_pkg::crate_conf_t  crate_conf_i,
    input  logic                     i2c_rdy_i,
    output logic                     enable_crate_o,
    output logic                     enable_3v3_o,
    // Housekeeping serial lines
    input  logic                     tctrl_b_i,
    input  logic                     dbg_rx_i,
    input  logic                     turf_rx_i,
    input  logic                     surf_tx_i,
    output logic                     dbg_tx_o,
    output logic                     turf_tx_o,
    output logic                     surf_rx_o
);

    import turfio_pkg::*;

    // Shared request to both slaves
    logic      s_we;
    win_addr_t s_adr;
    wb_data_t  s_dat;

    // Window 0 link
    logic      id_stb;
    logic      id_ack;
    wb_data_t  id_dat;

    // Window 1 link
    logic      hsk_stb;
    logic      hsk_ack;
    wb_data_t  hsk_dat;

    ////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////

    turfio_intercon u_intercon (
        .init_clk  (init_clk),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .id_dat_i  (id_dat),
        .id_ack_i  (id_ack),
        .id_stb_o  (id_stb),
        .hsk_dat_i (hsk_dat),
        .hsk_ack_i (hsk_ack),
        .hsk_stb_o (hsk_stb),
        .s_we_o    (s_we),
        .s_adr_o   (s_adr),
        .s_dat_o   (s_dat)
    );

    // Window 0, ident and crate enables
    tio_id_ctrl u_id_ctrl (
        .init_clk       (init_clk),
        .rst_n_i        (rst_n_i),
        .stb_i          (id_stb),
        .we_i           (s_we),
        .adr_i          (s_adr),
        .dat_i          (s_dat),
        .dat_o          (id_dat),
        .ack_o          (id_ack),
        .crate_conf_i   (crate_conf_i),
        .i2c_rdy_i      (i2c_rdy_i),
        .enable_crate_o (enable_crate_o),
        .enable_3v3_o   (enable_3v3_o)
    );

    // Window 1, housekeeping UART routing
    hskbus_route u_hskbus (
        .init_clk  (init_clk),
        .rst_n_i   (rst_n_i),
        .stb_i     (hsk_stb),
        .we_i      (s_we),
        .adr_i     (s_adr),
        .dat_i     (s_dat),
        .dat_o     (hsk_dat),
        .ack_o     (hsk_ack),
        .tctrl_b_i (tctrl_b_i),
        .dbg_rx_i  (dbg_rx_i),
        .turf_rx_i (turf_rx_i),
        .surf_tx_i (surf_tx_i),
        .dbg_tx_o  (dbg_tx_o),
        .turf_tx_o (turf_tx_o),
        .surf_rx_o (surf_rx_o)
    );

endmodule

// File: turfio_chk.sv
`timescale 1ns/100ps

module turfio_chk (
    input logic init_clk,
    input logic rst_n_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic wb_err_i
);

    logic req;
    logic resp;

    assign req  = wb_cyc_i & wb_stb_i;
    assign resp = wb_ack_i | wb_err_i;

    ////////////////////////////////////////
    // Wishbone response rules
    ////////////////////////////////////////

    // Exactly one kind of response at a time
    a_ack_err_excl: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        !(wb_ack_i && wb_err_i))
        else $error("ack and err high in the same cycle");

    // Registered response, so the request sits one cycle back
    a_resp_needs_req: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        resp |-> $past(req))
        else $error("response without a request in the previous cycle");

    // One-cycle latency
    a_resp_latency: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        $rose(req) |=> resp)
        else $error("request not answered on the next cycle");

    a_no_back_to_back: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        resp |=> !resp)
        else $error("response held for two cycles");

endmodule

bind turfio_top turfio_chk u_chk (
    .init_clk (init_clk),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .wb_err_i (wb_err_o)
);

// File: tb_turfio.sv
`timescale 1ns/100ps
`include "turfio_consts.svh"

module tb_turfio;

    import turfio_pkg::*;

    // About 300 cycles of traffic below, limit leaves a wide margin
    localparam int CYCLE_LIMIT = 2000;
    // Response is due one cycle after the request
    localparam int RESP_WAIT = 8;
    localparam logic [31:0] IDENT_EXP = "TFIO";
    // Date 0, version 0.2, revision 6
    localparam logic [31:0] DATEVER_EXP = 32'h0000_0206;

    logic        init_clk;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    wb_addr_t    wb_adr_i;
    wb_data_t    wb_dat_i;
    wb_data_t    wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    crate_conf_t crate_conf_i;
    logic        i2c_rdy_i;
    logic        enable_crate_o;
    logic        enable_3v3_o;
    logic        tctrl_b_i;
    logic        dbg_rx_i;
    logic        turf_rx_i;
    logic        surf_tx_i;
    logic        dbg_tx_o;
    logic        turf_tx_o;
    logic        surf_rx_o;

    // Random state and error tallies
    logic [31:0] rng = 32'ha93c;
    int          val_errs = 0;
    int          other_errs = 0;
    int          cycle_cnt = 0;

    turfio_top i_dut (.*);

    ////////////////////////////////////////
    // Clock and run limit
    ////////////////////////////////////////

    initial init_clk = 1'b0;
    always #4 init_clk = ~init_clk;

    always @(posedge init_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Space zero, window, offset
    function automatic wb_addr_t local_addr(input logic [9:0] win, input win_addr_t off);
        return {3'b000, win, off};
    endfunction

    // Expected {dbg_tx, turf_tx, surf_rx}, mode is {bridge, local}
    function automatic logic [2:0] route_model(input logic [1:0] mode, input logic tctrl,
                                               input logic dbg, input logic turf,
                                               input logic surf);
        logic turf_ok;
        logic to_crate;
        logic from_crate;
        turf_ok    = tctrl ? 1'b1 : turf;
        to_crate   = mode[0] ? dbg : turf_ok;
        from_crate = mode[1] ? surf : 1'b1;
        return {mode[0] ? from_crate : 1'b1, mode[0] ? 1'b1 : from_crate,
                mode[1] ? to_crate : 1'b1};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            val_errs++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // One classic cycle, drop stb once ack or err is seen
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat, output logic got_ack,
                             output logic got_err);
        int waited;
        waited = 0;
        @(negedge init_clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        @(negedge init_clk);
        while (!(wb_ack_o || wb_err_o) && waited < RESP_WAIT) begin
            @(negedge init_clk);
            waited++;
        end
        got_ack  = wb_ack_o;
        got_err  = wb_err_o;
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!(got_ack || got_err)) begin
            other_errs++;
            $display("No response from the DUT to the access at address %h", adr);
        end
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t wdat);
        wb_data_t rdat;
        logic     ack;
        logic     err;
        bus_cycle(1'b1, adr, wdat, rdat, ack, err);
        if (err) begin
            other_errs++;
            $display("Write to mapped address %h ended with err", adr);
        end
    endtask

    task automatic read_expect(input wb_addr_t adr, input wb_data_t exp, input string name);
        wb_data_t rdat;
        logic     ack;
        logic     err;
        bus_cycle(1'b0, adr, '0, rdat, ack, err);
        if (err) begin
            other_errs++;
            $display("Read of mapped address %h ended with err", adr);
        end else if (ack) begin
            check_value(name, exp, rdat);
        end
    endtask

    task automatic access_err(input logic we, input wb_addr_t adr);
        wb_data_t rdat;
        logic     ack;
        logic     err;
        bus_cycle(we, adr, rng, rdat, ack, err);
        assert (err && !ack) else begin
            other_errs++;
            $display("Access to unmapped address %h was not answered by err alone", adr);
        end
    endtask

    task automatic apply_reset();
        @(negedge init_clk);
        rst_n_i = 1'b0;
        repeat (3) @(negedge init_clk);
        rst_n_i = 1'b1;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        logic [1:0] mode;
        logic [2:0] exp_route;
        logic [9:0] w;
        wb_addr_t   a;
        rst_n_i      = 1'b0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        crate_conf_i = '0;
        i2c_rdy_i    = 1'b0;
        tctrl_b_i    = 1'b1;
        dbg_rx_i     = 1'b1;
        turf_rx_i    = 1'b1;
        surf_tx_i    = 1'b1;
        apply_reset();

        // Reset values and constants
        check_value("enable_crate_o", 32'd0, {31'd0, enable_crate_o});
        check_value("enable_3v3_o", 32'd0, {31'd0, enable_3v3_o});
        read_expect(local_addr(`WIN_ID_CTRL, `REG_CTRL), 32'd0, "ctrl");
        read_expect(local_addr(`WIN_HSKBUS, `REG_HSK_CTRL), 32'd0, "hsk_ctrl");
        read_expect(local_addr(`WIN_ID_CTRL, `REG_IDENT), IDENT_EXP, "ident");
        read_expect(local_addr(`WIN_ID_CTRL, `REG_DATEVER), DATEVER_EXP, "datever");

        // Control readback, only bits 1:0 stick
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            write_reg(local_addr(`WIN_ID_CTRL, `REG_CTRL), rng);
            check_value("enable_crate_o", {31'd0, rng[0]}, {31'd0, enable_crate_o});
            check_value("enable_3v3_o", {31'd0, rng[1]}, {31'd0, enable_3v3_o});
            read_expect(local_addr(`WIN_ID_CTRL, `REG_CTRL), {30'd0, rng[1:0]}, "ctrl");
        end
        rng = xorshift(rng);
        write_reg(local_addr(`WIN_ID_CTRL, `REG_IDENT), rng);
        write_reg(local_addr(`WIN_ID_CTRL, `REG_DATEVER), ~rng);
        read_expect(local_addr(`WIN_ID_CTRL, `REG_IDENT), IDENT_EXP, "ident");
        read_expect(local_addr(`WIN_ID_CTRL, `REG_DATEVER), DATEVER_EXP, "datever");

        // Pins into both status words
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            @(negedge init_clk);
            crate_conf_i = rng[1:0];
            i2c_rdy_i    = rng[2];
            tctrl_b_i    = rng[3];
            read_expect(local_addr(`WIN_ID_CTRL, `REG_STATUS), {29'd0, rng[2:0]}, "status");
            read_expect(local_addr(`WIN_HSKBUS, `REG_HSK_STAT), {31'd0, rng[3]}, "hsk_stat");
        end

        // All four routing modes with random line levels
        for (int m = 0; m < 4; m++) begin
            mode = m[1:0];
            rng  = xorshift(rng);
            write_reg(local_addr(`WIN_HSKBUS, `REG_HSK_CTRL), {rng[31:2], mode});
            read_expect(local_addr(`WIN_HSKBUS, `REG_HSK_CTRL), {30'd0, mode}, "hsk_ctrl");
            for (int i = 0; i < 8; i++) begin
                rng = xorshift(rng);
                @(negedge init_clk);
                tctrl_b_i = rng[0];
                dbg_rx_i  = rng[1];
                turf_rx_i = rng[2];
                surf_tx_i = rng[3];
                // Sample half a cycle later, lines long settled
                @(posedge init_clk);
                exp_route = route_model(mode, rng[0], rng[1], rng[2], rng[3]);
                check_value("dbg_tx_o", {31'd0, exp_route[2]}, {31'd0, dbg_tx_o});
                check_value("turf_tx_o", {31'd0, exp_route[1]}, {31'd0, turf_tx_o});
                check_value("surf_rx_o", {31'd0, exp_route[0]}, {31'd0, surf_rx_o});
            end
        end

        // SURF space and unmapped windows
        access_err(1'b0, local_addr(10'd2, 12'h000));
        access_err(1'b1, local_addr(10'd1023, 12'hFFC));
        for (int i = 0; i < 12; i++) begin
            rng = xorshift(rng);
            a   = rng[24:0];
            if (a[24:22] == 3'b000) begin
                a[22] = 1'b1;
            end
            access_err(rng[25], a);
            rng = xorshift(rng);
            w   = rng[9:0];
            if (w < 10'd2) begin
                w = w + 10'd2;
            end
            access_err(rng[10], local_addr(w, rng[23:12]));
        end
        read_expect(local_addr(`WIN_ID_CTRL, `REG_IDENT), IDENT_EXP, "ident");

        // Mid-run reset clears both control registers
        write_reg(local_addr(`WIN_ID_CTRL, `REG_CTRL), 32'h3);
        write_reg(local_addr(`WIN_HSKBUS, `REG_HSK_CTRL), 32'h3);
        check_value("enable_crate_o", 32'd1, {31'd0, enable_crate_o});
        check_value("enable_3v3_o", 32'd1, {31'd0, enable_3v3_o});
        read_expect(local_addr(`WIN_HSKBUS, `REG_HSK_CTRL), 32'h3, "hsk_ctrl");
        apply_reset();
        check_value("enable_crate_o", 32'd0, {31'd0, enable_crate_o});
        check_value("enable_3v3_o", 32'd0, {31'd0, enable_3v3_o});
        read_expect(local_addr(`WIN_ID_CTRL, `REG_CTRL), 32'd0, "ctrl");
        read_expect(local_addr(`WIN_HSKBUS, `REG_HSK_CTRL), 32'd0, "hsk_ctrl");

        $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+.
turfio_pkg.sv
turfio_intercon.sv
tio_id_ctrl.sv
hskbus_route.sv
turfio_top.sv
turfio_chk.sv
tb_turfio.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_turfio -f src.f \
    && ./obj_dir/Vtb_turfio | tee /dev/stderr | grep "RESULT: PASS" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
